// ==== isa_pkg.sv ====
// instruction set subset only; no byte or halfword loads and stores, bit 31 is always zero
package isa_pkg;

  // major opcodes, bits 30..25 of the instruction word
  typedef enum logic [5:0] {
    TYPE_BASIC = 6'b100000,
    TYPE_LS    = 6'b011100,
    ADDI       = 6'b101000,
    ORI        = 6'b101100,
    XORI       = 6'b101011,
    MOVI       = 6'b100010,
    LWI        = 6'b000010,
    SWI        = 6'b001010,
    BEQ        = 6'b100110,
    J          = 6'b100100
  } opcode_e;

  // sub-opcodes of the basic type, low five bits of the tail
  typedef enum logic [4:0] {
    ADD   = 5'b00000,
    SUB   = 5'b00001,
    AND   = 5'b00010,
    XOR   = 5'b00011,
    OR    = 5'b00100,
    SLLI  = 5'b01000,
    SRLI  = 5'b01001,
    ROTRI = 5'b01011
  } sub5_e;

  // sub-opcodes of the load/store type, low eight bits of the tail
  typedef enum logic [7:0] {
    LW = 8'b00000010,
    SW = 8'b00001010
  } sub8_e;

  // instruction word; the tail is sliced by the decoder
  //   tail[14:10] rb or shift amount
  //   tail[9:8]   sv scale for LW/SW
  //   tail[7:0]   sub8, tail[4:0] sub5
  //   tail[14:0]  imm15, tail[13:0] branch offset
  //   {ra, tail}  imm20 for MOVI, {rt[3:0], ra, tail} imm24 for J
  typedef struct packed {
    logic      zero;
    opcode_e   opcode;
    logic [4:0] rt;
    logic [4:0] ra;
    logic [14:0] tail;
  } instr_t;

  // SRLI r0, r0, 0 is the NOP and writes nothing
  localparam logic [31:0] NOP_WORD = 32'h4000_0009;

endpackage

// ==== core_pkg.sv ====
// core-internal types; the decoded operation assumes the isa_pkg field layout
package core_pkg;

  // decoded operation handed from the decoder to the ALU and the control
  typedef struct packed {
    isa_pkg::opcode_e opcode;
    isa_pkg::sub5_e   sub5;
    isa_pkg::sub8_e   sub8;
    logic [1:0]       sv;
    logic [4:0]       rt;
    logic [4:0]       ra_idx;
    logic [4:0]       rb_idx;
    logic [31:0]      imm;
    logic             use_imm;
    logic             wb_en;
    logic             mem_rd;
    logic             mem_wr;
    logic             is_branch;
  } dec_op_t;

  typedef struct packed {
    logic [31:0] result;
    logic        overflow;
    logic        pc_set;
  } alu_out_t;

  // one record per retired instruction
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] next_pc;
    logic        wb_en;
    logic [4:0]  wb_reg;
    logic [31:0] wb_data;
    logic        overflow;
    logic        mem_wr;
    logic [31:0] mem_addr;
  } retire_t;

  typedef enum logic [1:0] {
    IDLE,
    EXEC,
    MEM,
    RETIRE
  } ctrl_state_e;

endpackage

// ==== instr_decoder.sv ====
// purely combinational; unknown opcodes and sub-opcodes decode to an operation that writes nothing
`timescale 1ns/100ps

module instr_decoder (
  input  isa_pkg::instr_t   instr,
  output core_pkg::dec_op_t op
);

  logic [31:0] imm15_s;
  logic [31:0] imm15_z;
  logic [31:0] imm20_s;
  logic [31:0] imm14_s;
  logic [31:0] imm24_s;

  assign imm15_s = {{17{instr.tail[14]}}, instr.tail};
  assign imm15_z = {17'b0, instr.tail};
  assign imm20_s = {{12{instr.ra[4]}}, instr.ra, instr.tail};
  assign imm14_s = {{18{instr.tail[13]}}, instr.tail[13:0]};
  assign imm24_s = {{8{instr.rt[3]}}, instr.rt[3:0], instr.ra, instr.tail};

  always_comb begin
    op        = '0;
    op.opcode = instr.opcode;
    op.sub5   = isa_pkg::sub5_e'(instr.tail[4:0]);
    op.sub8   = isa_pkg::sub8_e'(instr.tail[7:0]);
    op.sv     = instr.tail[9:8];
    op.rt     = instr.rt;
    op.ra_idx = instr.ra;
    op.rb_idx = instr.tail[14:10];

    case (instr.opcode)
      isa_pkg::TYPE_BASIC: begin
        case (op.sub5)
          isa_pkg::ADD, isa_pkg::SUB, isa_pkg::AND, isa_pkg::OR, isa_pkg::XOR: begin
            op.wb_en = 1'b1;
          end
          isa_pkg::SRLI, isa_pkg::SLLI, isa_pkg::ROTRI: begin
            // shift amount sits in the rb field
            op.imm     = {27'b0, instr.tail[14:10]};
            op.use_imm = 1'b1;
            op.wb_en   = (instr != isa_pkg::NOP_WORD);
          end
          default: op.wb_en = 1'b0;
        endcase
      end
      isa_pkg::ADDI: begin
        op.imm     = imm15_s;
        op.use_imm = 1'b1;
        op.wb_en   = 1'b1;
      end
      isa_pkg::ORI, isa_pkg::XORI: begin
        op.imm     = imm15_z;
        op.use_imm = 1'b1;
        op.wb_en   = 1'b1;
      end
      isa_pkg::MOVI: begin
        op.imm     = imm20_s;
        op.use_imm = 1'b1;
        op.wb_en   = 1'b1;
      end
      isa_pkg::LWI: begin
        op.imm     = imm15_s;
        op.use_imm = 1'b1;
        op.wb_en   = 1'b1;
        op.mem_rd  = 1'b1;
      end
      isa_pkg::SWI: begin
        op.imm     = imm15_s;
        op.use_imm = 1'b1;
        op.mem_wr  = 1'b1;
        op.rb_idx  = instr.rt;
      end
      isa_pkg::TYPE_LS: begin
        // rb stays the index register, store data is read from rt at retire
        if (op.sub8 == isa_pkg::LW) begin
          op.wb_en  = 1'b1;
          op.mem_rd = 1'b1;
        end else if (op.sub8 == isa_pkg::SW) begin
          op.mem_wr = 1'b1;
        end
      end
      isa_pkg::BEQ: begin
        op.imm       = imm14_s;
        op.rb_idx    = instr.rt;
        op.is_branch = 1'b1;
      end
      isa_pkg::J: begin
        op.imm       = imm24_s;
        op.is_branch = 1'b1;
      end
      default: op.wb_en = 1'b0;
    endcase
  end

endmodule

// ==== reg_file.sv ====
// r0 is an ordinary writable register; reads do not see a write in the same cycle
`timescale 1ns/100ps

module reg_file (
  input  logic        clock,
  input  logic        reset,
  input  logic [4:0]  ra_idx,
  input  logic [4:0]  rb_idx,
  output logic [31:0] ra_data,
  output logic [31:0] rb_data,
  input  logic        we,
  input  logic [4:0]  w_idx,
  input  logic [31:0] w_data
);

  logic [31:0] regs [32];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[w_idx] <= w_data;
    end
  end

  // two asynchronous read ports
  assign ra_data = regs[ra_idx];
  assign rb_data = regs[rb_idx];

endmodule

// ==== alu32.sv ====
// combinational; only ADD, SUB and ADDI flag signed overflow, unknown opcodes give zero
`timescale 1ns/100ps

module alu32 (
  input  core_pkg::dec_op_t  op,
  input  logic [31:0]        scr1,
  input  logic [31:0]        scr2,
  output core_pkg::alu_out_t out
);

  logic [31:0] sum;
  logic [31:0] diff;
  logic        sum_ovf;
  logic        diff_ovf;
  logic [4:0]  shamt;
  logic [63:0] rot;
  logic [31:0] ls_addr;

  assign sum      = scr1 + scr2;
  assign diff     = scr1 - scr2;
  assign sum_ovf  = (scr1[31] == scr2[31]) && (sum[31] != scr1[31]);
  assign diff_ovf = (scr1[31] != scr2[31]) && (diff[31] != scr1[31]);
  assign shamt    = scr2[4:0];
  assign rot      = {scr1, scr1} >> shamt;
  // scaled index address for LW and SW
  assign ls_addr  = scr1 + (scr2 << op.sv);

  always_comb begin
    out = '0;
    case (op.opcode)
      isa_pkg::TYPE_BASIC: begin
        case (op.sub5)
          isa_pkg::ADD: begin
            out.result   = sum;
            out.overflow = sum_ovf;
          end
          isa_pkg::SUB: begin
            out.result   = diff;
            out.overflow = diff_ovf;
          end
          isa_pkg::AND:   out.result = scr1 & scr2;
          isa_pkg::OR:    out.result = scr1 | scr2;
          isa_pkg::XOR:   out.result = scr1 ^ scr2;
          isa_pkg::SRLI:  out.result = scr1 >> shamt;
          isa_pkg::SLLI:  out.result = scr1 << shamt;
          isa_pkg::ROTRI: out.result = rot[31:0];
          default:        out.result = '0;
        endcase
      end
      isa_pkg::ADDI: begin
        out.result   = sum;
        out.overflow = sum_ovf;
      end
      isa_pkg::ORI:  out.result = scr1 | scr2;
      isa_pkg::XORI: out.result = scr1 ^ scr2;
      isa_pkg::MOVI: out.result = scr2;
      // word offset, scaled by four
      isa_pkg::LWI, isa_pkg::SWI: out.result = scr1 + (scr2 << 2);
      isa_pkg::TYPE_LS: begin
        if (op.sub8 == isa_pkg::LW || op.sub8 == isa_pkg::SW) begin
          out.result = ls_addr;
        end
      end
      // scr2 carries the rt value for the compare
      isa_pkg::BEQ: out.pc_set = (scr1 == scr2);
      isa_pkg::J:   out.pc_set = 1'b1;
      default:      out = '0;
    endcase
  end

endmodule

// ==== data_mem.sv ====
// DMEM_WORDS must be a power of two; contents start at zero at power-up, not on reset
`timescale 1ns/100ps

module data_mem #(
  parameter int DMEM_WORDS = 256
) (
  input  logic        clock,
  input  logic [31:0] addr,
  input  logic        we,
  input  logic [31:0] wdata,
  output logic [31:0] rdata
);

  localparam int AW = $clog2(DMEM_WORDS);

  logic [31:0]   mem [DMEM_WORDS];
  logic [AW-1:0] idx;

  // word index, byte offset bits dropped, wraps at the depth
  assign idx = addr[AW+1:2];

  initial begin
    for (int i = 0; i < DMEM_WORDS; i++) begin
      mem[i] = '0;
    end
  end

  always_ff @(posedge clock) begin
    if (we) begin
      mem[idx] <= wdata;
    end
    rdata <= mem[idx];
  end

endmodule

// ==== exec_control.sv ====
// one instruction at a time; a strobe outside IDLE is dropped, loads retire one cycle later
`timescale 1ns/100ps

module exec_control #(
  parameter logic [31:0] RESET_PC   = 32'h0,
  parameter int          DMEM_WORDS = 256
) (
  input  logic               clock,
  input  logic               reset,
  input  logic               instr_valid,
  input  isa_pkg::instr_t    instr,
  output logic               ready,
  output isa_pkg::instr_t    cur_instr,
  input  core_pkg::dec_op_t  op,
  input  logic [31:0]        rb_data,
  input  core_pkg::alu_out_t alu,
  input  logic [31:0]        mem_rdata,
  output logic               mem_we,
  output logic [31:0]        mem_addr,
  output logic [31:0]        mem_wdata,
  output logic               rf_we,
  output logic [4:0]         rf_idx,
  output logic [31:0]        rf_wdata,
  output logic               retire_valid,
  output core_pkg::retire_t  retire
);

  localparam int AW = $clog2(DMEM_WORDS);

  core_pkg::ctrl_state_e state;
  core_pkg::alu_out_t    alu_q;
  logic [31:0]           pc;
  logic [31:0]           next_pc;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= core_pkg::IDLE;
      pc    <= RESET_PC;
    end else begin
      case (state)
        core_pkg::IDLE:   if (instr_valid) state <= core_pkg::EXEC;
        core_pkg::EXEC:   state <= op.mem_rd ? core_pkg::MEM : core_pkg::RETIRE;
        core_pkg::MEM:    state <= core_pkg::RETIRE;
        core_pkg::RETIRE: begin
          state <= core_pkg::IDLE;
          pc    <= next_pc;
        end
        default:          state <= core_pkg::IDLE;
      endcase
    end
  end

  // instruction and ALU result registers
  always_ff @(posedge clock) begin
    if (state == core_pkg::IDLE && instr_valid) begin
      cur_instr <= instr;
    end
    if (state == core_pkg::EXEC) begin
      alu_q <= alu;
    end
  end

  assign ready        = (state == core_pkg::IDLE);
  assign retire_valid = (state == core_pkg::RETIRE);

  // branch offsets count halfwords
  assign next_pc = (op.is_branch && alu_q.pc_set) ? pc + (op.imm << 1) : pc + 32'd4;

  assign mem_addr  = {{(30 - AW){1'b0}}, alu_q.result[AW+1:2], 2'b00};
  assign mem_we    = retire_valid && op.mem_wr;
  assign mem_wdata = rb_data;

  assign rf_we    = retire_valid && op.wb_en;
  assign rf_idx   = op.rt;
  assign rf_wdata = op.mem_rd ? mem_rdata : alu_q.result;

  always_comb begin
    retire          = '0;
    retire.pc       = pc;
    retire.next_pc  = next_pc;
    retire.wb_en    = op.wb_en;
    retire.wb_reg   = op.wb_en ? op.rt : 5'd0;
    retire.wb_data  = op.wb_en ? rf_wdata : 32'd0;
    retire.overflow = alu_q.overflow;
    retire.mem_wr   = op.mem_wr;
    retire.mem_addr = (op.mem_rd || op.mem_wr) ? mem_addr : 32'd0;
  end

endmodule

// ==== exec_core.sv ====
// execute core without fetch; the environment strobes instructions only while ready is high
`timescale 1ns/100ps

module exec_core #(
  parameter logic [31:0] RESET_PC   = 32'h0,
  parameter int          DMEM_WORDS = 256
) (
  input  logic              clock,
  input  logic              reset,
  input  logic              instr_valid,
  input  isa_pkg::instr_t   instr,
  output logic              ready,
  output logic              retire_valid,
  output core_pkg::retire_t retire
);

  isa_pkg::instr_t    cur_instr;
  core_pkg::dec_op_t  op;
  core_pkg::alu_out_t alu_out;
  logic [31:0]        ra_data;
  logic [31:0]        rb_data;
  logic [4:0]         rb_idx;
  logic [31:0]        scr2;
  logic               mem_we;
  logic [31:0]        mem_addr;
  logic [31:0]        mem_wdata;
  logic [31:0]        mem_rdata;
  logic               rf_we;
  logic [4:0]         rf_idx;
  logic [31:0]        rf_wdata;

  // second port reads the store data from rt while a store retires
  assign rb_idx = (retire_valid && op.mem_wr) ? op.rt : op.rb_idx;
  assign scr2   = op.use_imm ? op.imm : rb_data;

  exec_control #(
    .RESET_PC   (RESET_PC),
    .DMEM_WORDS (DMEM_WORDS)
  ) ctrl0 (
    .clock        (clock),
    .reset        (reset),
    .instr_valid  (instr_valid),
    .instr        (instr),
    .ready        (ready),
    .cur_instr    (cur_instr),
    .op           (op),
    .rb_data      (rb_data),
    .alu          (alu_out),
    .mem_rdata    (mem_rdata),
    .mem_we       (mem_we),
    .mem_addr     (mem_addr),
    .mem_wdata    (mem_wdata),
    .rf_we        (rf_we),
    .rf_idx       (rf_idx),
    .rf_wdata     (rf_wdata),
    .retire_valid (retire_valid),
    .retire       (retire)
  );

  instr_decoder dec0 (
    .instr (cur_instr),
    .op    (op)
  );

  reg_file rf0 (
    .clock   (clock),
    .reset   (reset),
    .ra_idx  (op.ra_idx),
    .rb_idx  (rb_idx),
    .ra_data (ra_data),
    .rb_data (rb_data),
    .we      (rf_we),
    .w_idx   (rf_idx),
    .w_data  (rf_wdata)
  );

  alu32 alu0 (
    .op   (op),
    .scr1 (ra_data),
    .scr2 (scr2),
    .out  (alu_out)
  );

  data_mem #(
    .DMEM_WORDS (DMEM_WORDS)
  ) dmem0 (
    .clock (clock),
    .addr  (mem_addr),
    .we    (mem_we),
    .wdata (mem_wdata),
    .rdata (mem_rdata)
  );

endmodule

// ==== tb_exec_core.sv ====
// self-checking testbench; model starts with all registers and memory words at zero
`timescale 1ns/100ps

module tb_exec_core;

  localparam int          CLK_PERIOD = 8;
  localparam int          DMEM_WORDS = 256;
  localparam logic [31:0] RESET_PC   = 32'h0000_0040;
  localparam int          WAIT_LIMIT = 40;

  logic              clock = 1'b0;
  logic              reset;
  logic              instr_valid;
  isa_pkg::instr_t   instr;
  logic              ready;
  logic              retire_valid;
  core_pkg::retire_t retire;

  // architectural state of the reference model
  logic [31:0] m_regs [32];
  logic [31:0] m_mem [DMEM_WORDS];
  logic [31:0] m_pc;

  // expected records in accept order, with latency and accept time
  core_pkg::retire_t exp_q [$];
  int                lat_q [$];
  longint            acc_q [$];
  integer            seed;

  exec_core #(
    .RESET_PC   (RESET_PC),
    .DMEM_WORDS (DMEM_WORDS)
  ) dut0 (
    .clock        (clock),
    .reset        (reset),
    .instr_valid  (instr_valid),
    .instr        (instr),
    .ready        (ready),
    .retire_valid (retire_valid),
    .retire       (retire)
  );

  always #(CLK_PERIOD / 2) clock = ~clock;

  task automatic finish_failed();
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at the first failure");
  endtask

  task automatic value_mismatch(input string what, input logic [31:0] exp, input logic [31:0] got);
    $display("error at %0t ns: %s expected %h, got %h", $time, what, exp, got);
    finish_failed();
  endtask

  task automatic check_retire(input core_pkg::retire_t got, input core_pkg::retire_t exp);
    if (got.pc !== exp.pc) value_mismatch("pc", exp.pc, got.pc);
    if (got.next_pc !== exp.next_pc) value_mismatch("next_pc", exp.next_pc, got.next_pc);
    if (got.wb_en !== exp.wb_en) value_mismatch("wb_en", 32'(exp.wb_en), 32'(got.wb_en));
    if (got.wb_reg !== exp.wb_reg) value_mismatch("wb_reg", 32'(exp.wb_reg), 32'(got.wb_reg));
    if (got.wb_data !== exp.wb_data) value_mismatch("wb_data", exp.wb_data, got.wb_data);
    if (got.overflow !== exp.overflow) begin
      value_mismatch("overflow", 32'(exp.overflow), 32'(got.overflow));
    end
    if (got.mem_wr !== exp.mem_wr) value_mismatch("mem_wr", 32'(exp.mem_wr), 32'(got.mem_wr));
    if (got.mem_addr !== exp.mem_addr) value_mismatch("mem_addr", exp.mem_addr, got.mem_addr);
  endtask

  task automatic check_ready(input logic exp_level);
    if (ready !== exp_level) value_mismatch("ready", 32'(exp_level), 32'(ready));
  endtask

  task automatic check_latency(input int exp, input int got);
    if (got != exp) value_mismatch("retire latency in cycles", 32'(exp), 32'(got));
  endtask

  function automatic isa_pkg::instr_t pack_word(input isa_pkg::opcode_e opc, input logic [4:0] rt,
                                                input logic [4:0] ra, input logic [14:0] tail);
    isa_pkg::instr_t w;
    w        = '0;
    w.opcode = opc;
    w.rt     = rt;
    w.ra     = ra;
    w.tail   = tail;
    return w;
  endfunction

  function automatic isa_pkg::sub5_e pick_sub5(input logic [2:0] k);
    case (k)
      3'd0:    return isa_pkg::ADD;
      3'd1:    return isa_pkg::SUB;
      3'd2:    return isa_pkg::AND;
      3'd3:    return isa_pkg::OR;
      3'd4:    return isa_pkg::XOR;
      3'd5:    return isa_pkg::SRLI;
      3'd6:    return isa_pkg::SLLI;
      default: return isa_pkg::ROTRI;
    endcase
  endfunction

  // executes one instruction on the model state and returns the expected record
  function automatic core_pkg::retire_t ref_exec(input isa_pkg::instr_t w);
    core_pkg::retire_t r;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [31:0] addr;
    logic [31:0] off;
    logic [4:0]  rb;
    logic        take;
    logic        arith;
    logic        is_ld;
    logic        is_st;
    longint      wide;
    int          widx;
    r       = '0;
    rb      = w.tail[14:10];
    a       = m_regs[w.ra];
    b       = m_regs[rb];
    res     = '0;
    addr    = '0;
    off     = '0;
    take    = 1'b0;
    arith   = 1'b0;
    is_ld   = 1'b0;
    is_st   = 1'b0;
    wide    = 0;
    widx    = 0;
    r.wb_en = 1'b1;
    case (w.opcode)
      isa_pkg::TYPE_BASIC: begin
        case (w.tail[4:0])
          isa_pkg::ADD: begin
            wide  = longint'($signed(a)) + longint'($signed(b));
            arith = 1'b1;
          end
          isa_pkg::SUB: begin
            wide  = longint'($signed(a)) - longint'($signed(b));
            arith = 1'b1;
          end
          isa_pkg::AND:   res = a & b;
          isa_pkg::OR:    res = a | b;
          isa_pkg::XOR:   res = a ^ b;
          isa_pkg::SLLI:  res = a << rb;
          isa_pkg::ROTRI: res = (a >> rb) | (a << (6'd32 - 6'(rb)));
          isa_pkg::SRLI: begin
            res = a >> rb;
            // SRLI r0, r0, 0 is the NOP
            r.wb_en = (w.rt != 5'd0) || (w.ra != 5'd0) || (w.tail[14:5] != 10'd0);
          end
          default: r.wb_en = 1'b0;
        endcase
      end
      isa_pkg::ADDI: begin
        wide  = longint'($signed(a)) + longint'($signed(w.tail));
        arith = 1'b1;
      end
      isa_pkg::ORI:  res = a | {17'b0, w.tail};
      isa_pkg::XORI: res = a ^ {17'b0, w.tail};
      isa_pkg::MOVI: res = 32'($signed({w.ra, w.tail}));
      isa_pkg::LWI, isa_pkg::SWI: begin
        addr  = a + (32'($signed(w.tail)) << 2);
        is_ld = (w.opcode == isa_pkg::LWI);
        is_st = !is_ld;
      end
      isa_pkg::TYPE_LS: begin
        addr  = a + (b << w.tail[9:8]);
        is_ld = (w.tail[7:0] == isa_pkg::LW);
        is_st = (w.tail[7:0] == isa_pkg::SW);
      end
      isa_pkg::BEQ: begin
        take = (a == m_regs[w.rt]);
        off  = 32'($signed(w.tail[13:0])) << 1;
      end
      isa_pkg::J: begin
        take = 1'b1;
        off  = 32'($signed({w.rt[3:0], w.ra, w.tail})) << 1;
      end
      default: r.wb_en = 1'b0;
    endcase
    if (arith) begin
      res        = wide[31:0];
      r.overflow = (wide != longint'($signed(res)));
    end
    if (is_ld || is_st) begin
      widx       = int'((addr >> 2) % DMEM_WORDS);
      r.mem_addr = 32'(widx) << 2;
    end
    if (is_ld) res = m_mem[widx];
    if (is_st) m_mem[widx] = m_regs[w.rt];
    if (is_st || w.opcode == isa_pkg::BEQ || w.opcode == isa_pkg::J) r.wb_en = 1'b0;
    if (w.opcode == isa_pkg::TYPE_LS && !is_ld) r.wb_en = 1'b0;
    r.mem_wr = is_st;
    if (r.wb_en) begin
      r.wb_reg     = w.rt;
      r.wb_data    = res;
      m_regs[w.rt] = res;
    end
    r.pc      = m_pc;
    r.next_pc = take ? m_pc + off : m_pc + 32'd4;
    m_pc      = r.next_pc;
    return r;
  endfunction

  task automatic wait_ready();
    int n;
    n = 0;
    @(negedge clock);
    while (ready !== 1'b1) begin
      n++;
      if (n > WAIT_LIMIT) begin
        $display("timeout: ready stayed low for %0d cycles", WAIT_LIMIT);
        finish_failed();
      end
      @(negedge clock);
    end
  endtask

  // strobe one instruction; stray adds a second strobe while the core is busy
  task automatic issue(input isa_pkg::instr_t w, input logic stray);
    core_pkg::retire_t e;
    logic              ld;
    wait_ready();
    e  = ref_exec(w);
    ld = (w.opcode == isa_pkg::LWI) || (w.opcode == isa_pkg::TYPE_LS && w.tail[7:0] == 8'h02);
    @(posedge clock);
    instr_valid <= 1'b1;
    instr       <= w;
    @(posedge clock);
    exp_q.push_back(e);
    lat_q.push_back(ld ? 2 : 1);
    acc_q.push_back($time);
    if (stray) begin
      instr <= pack_word(isa_pkg::MOVI, 5'd31, 5'h0a, 15'h1234);
      @(posedge clock);
    end
    instr_valid <= 1'b0;
    @(negedge clock);
    check_ready(1'b0);
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_q.size() != 0) begin
      @(negedge clock);
      n++;
      if (n > WAIT_LIMIT) begin
        $display("timeout: %0d accepted instructions never retired", exp_q.size());
        finish_failed();
      end
    end
    repeat (4) @(negedge clock);
  endtask

  initial begin : compare_retire
    core_pkg::retire_t exp_rec;
    longint            acc;
    int                lat;
    int                idle;
    idle = 0;
    forever begin
      @(negedge clock);
      if (reset === 1'b1) begin
        idle = 0;
      end else if (retire_valid === 1'b1) begin
        if (exp_q.size() == 0) begin
          $display("retire_valid went high with no accepted instruction outstanding");
          finish_failed();
        end else begin
          exp_rec = exp_q.pop_front();
          lat     = lat_q.pop_front();
          acc     = acc_q.pop_front();
          check_retire(retire, exp_rec);
          check_latency(lat, int'(($time - acc) / CLK_PERIOD));
          idle = 0;
        end
      end else if (exp_q.size() != 0) begin
        idle++;
        if (idle > WAIT_LIMIT) begin
          $display("timeout: no retire for an accepted instruction");
          finish_failed();
        end
      end
    end
  end

  initial begin : stimulus
    logic [31:0] r;
    logic [31:0] f;
    seed        = 32'hc4ee_8e08;
    reset       = 1'b1;
    instr_valid = 1'b0;
    instr       = '0;
    m_pc        = RESET_PC;
    for (int i = 0; i < 32; i++) begin
      m_regs[i] = '0;
    end
    for (int i = 0; i < DMEM_WORDS; i++) begin
      m_mem[i] = '0;
    end
    repeat (10) @(posedge clock);
    reset <= 1'b0;
    repeat (4) begin
      @(negedge clock);
      check_ready(1'b1);
    end

    // fill registers, then random ALU and immediate operations
    for (int i = 0; i < 32; i++) begin
      r = $random(seed);
      issue(pack_word(isa_pkg::MOVI, 5'(i), r[19:15], r[14:0]), 1'b0);
    end
    for (int i = 0; i < 80; i++) begin
      r = $random(seed);
      f = $random(seed);
      case (r[2:0])
        3'd0:    issue(pack_word(isa_pkg::ADDI, f[4:0], f[9:5], r[31:17]), 1'b0);
        3'd1:    issue(pack_word(isa_pkg::ORI, f[4:0], f[9:5], r[31:17]), 1'b0);
        3'd2:    issue(pack_word(isa_pkg::XORI, f[4:0], f[9:5], r[31:17]), 1'b0);
        3'd3:    issue(pack_word(isa_pkg::MOVI, f[4:0], r[31:27], r[26:12]), 1'b0);
        default: issue(pack_word(isa_pkg::TYPE_BASIC, f[4:0], f[9:5],
                                 {f[14:10], 5'b0, pick_sub5(f[17:15])}), 1'b0);
      endcase
    end

    // overflow at the largest positive value
    issue(pack_word(isa_pkg::MOVI, 5'd1, 5'h1f, 15'h7fff), 1'b0);
    issue(pack_word(isa_pkg::TYPE_BASIC, 5'd1, 5'd1, {5'd1, 5'b0, isa_pkg::SRLI}), 1'b0);
    issue(pack_word(isa_pkg::MOVI, 5'd2, 5'd0, 15'd1), 1'b0);
    issue(pack_word(isa_pkg::TYPE_BASIC, 5'd3, 5'd1, {5'd2, 5'b0, isa_pkg::ADD}), 1'b0);
    issue(pack_word(isa_pkg::ADDI, 5'd4, 5'd1, 15'd1), 1'b0);
    issue(pack_word(isa_pkg::TYPE_BASIC, 5'd5, 5'd2, {5'd31, 5'b0, isa_pkg::SLLI}), 1'b0);
    issue(pack_word(isa_pkg::TYPE_BASIC, 5'd6, 5'd5, {5'd2, 5'b0, isa_pkg::SUB}), 1'b0);

    // shift amounts 0 and 31, then the NOP
    for (int i = 5; i < 8; i++) begin
      issue(pack_word(isa_pkg::TYPE_BASIC, 5'd7, 5'd1, {5'd0, 5'b0, pick_sub5(3'(i))}), 1'b0);
      issue(pack_word(isa_pkg::TYPE_BASIC, 5'd8, 5'd6, {5'd31, 5'b0, pick_sub5(3'(i))}), 1'b0);
    end
    issue(pack_word(isa_pkg::TYPE_BASIC, 5'd0, 5'd0, {10'b0, isa_pkg::SRLI}), 1'b0);

    // memory round trips
    for (int i = 0; i < 12; i++) begin
      r = $random(seed);
      f = $random(seed);
      issue(pack_word(isa_pkg::SWI, f[4:0], f[9:5], r[14:0]), 1'b0);
      issue(pack_word(isa_pkg::LWI, f[14:10], f[9:5], r[14:0]), 1'b0);
    end
    for (int sv = 0; sv < 4; sv++) begin
      repeat (3) begin
        f = $random(seed);
        issue(pack_word(isa_pkg::TYPE_LS, f[4:0], f[9:5], {f[14:10], 2'(sv), isa_pkg::SW}), 1'b0);
        issue(pack_word(isa_pkg::TYPE_LS, f[19:15], f[9:5], {f[14:10], 2'(sv), isa_pkg::LW}), 1'b0);
      end
    end

    // control flow, taken and not taken
    issue(pack_word(isa_pkg::BEQ, 5'd3, 5'd3, 15'h0040), 1'b0);
    issue(pack_word(isa_pkg::BEQ, 5'd1, 5'd2, 15'h0040), 1'b0);
    issue(pack_word(isa_pkg::J, 5'h00, 5'h00, 15'h0100), 1'b0);
    issue(pack_word(isa_pkg::J, 5'h0f, 5'h1f, 15'h7ff0), 1'b0);
    for (int i = 0; i < 6; i++) begin
      f = $random(seed);
      issue(pack_word(isa_pkg::BEQ, f[4:0], f[2] ? f[4:0] : f[9:5], f[24:10]), 1'b0);
      issue(pack_word(isa_pkg::ADDI, f[29:25], f[4:0], 15'd3), 1'b0);
    end

    // strobes while busy must be ignored
    issue(pack_word(isa_pkg::LWI, 5'd9, 5'd2, 15'd5), 1'b1);
    issue(pack_word(isa_pkg::TYPE_BASIC, 5'd10, 5'd9, {5'd1, 5'b0, isa_pkg::ADD}), 1'b1);
    issue(pack_word(isa_pkg::SWI, 5'd10, 5'd2, 15'd6), 1'b1);

    wait_drain();
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// ==== build.f ====
isa_pkg.sv
core_pkg.sv
instr_decoder.sv
reg_file.sv
alu32.sv
data_mem.sv
exec_control.sv
exec_core.sv
tb_exec_core.sv

// ==== Makefile ====
# Verilator flow for the execute core testbench
SIM = obj_dir/sim_exec_core

.PHONY: compile run clean

compile:
	verilator --binary --timing --top-module tb_exec_core -f build.f -o sim_exec_core

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir
